// File: all.f
verilog/ia_pkg.sv
verilog/tile_sequencer.sv
verilog/icb_row_reader.sv
verilog/tile_buffer.sv
verilog/row_sender.sv
verilog/ia_loader_top.sv
verif/icb_mem_model.sv
verif/tb_ia_loader.sv

// File: run.sh
#!/bin/sh
# build the activation loader testbench with Verilator and run it
# exit status is nonzero when the build fails or the simulation stops on $fatal
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f all.f \
        --top-module tb_ia_loader -o tb_ia_loader \
    && ./obj_dir/tb_ia_loader \
    || { echo "run.sh: build or simulation failed"; exit 1; }

// File: verif/icb_mem_model.sv
/*
 * ICB slave memory for the loader testbench
 * 4 KB byte store, random command ready, random response stalls
 */
module icb_mem_model (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         icb_cmd_valid,
    output logic                         icb_cmd_ready,
    input  logic                         icb_cmd_read,
    input  logic [ia_pkg::reg_width-1:0] icb_cmd_addr,
    input  logic [ia_pkg::len_width-1:0] icb_cmd_len,
    output logic                         icb_rsp_valid,
    input  logic                         icb_rsp_ready,
    output logic [ia_pkg::bus_width-1:0] icb_rsp_rdata
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int mem_bytes = 4096;

    logic [7:0]  mem [mem_bytes];  // filled by the testbench
    int unsigned beat_q [$];       // one address per pending beat
    int unsigned beat_addr;

    // little endian, lowest byte in lane 0
    function automatic logic [ia_pkg::bus_width-1:0] beat_data(input int unsigned a);
        logic [ia_pkg::bus_width-1:0] d;
        for (int i = 0; i < ia_pkg::bytes_per_beat; i++) begin
            d[8*i +: 8] = mem[(a + i) % mem_bytes];
        end
        return d;
    endfunction

    // ==================================================
    // command intake and in-order responses
    // ==================================================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            icb_cmd_ready <= 1'b0;
            icb_rsp_valid <= 1'b0;
            icb_rsp_rdata <= '0;
            beat_q.delete();
        end else begin
            if (icb_cmd_valid && icb_cmd_ready && icb_cmd_read == ia_pkg::READ) begin
                for (int j = 0; j <= int'(icb_cmd_len); j++) begin
                    beat_q.push_back(int'(icb_cmd_addr) + ia_pkg::bytes_per_beat * j);
                end
            end
            icb_cmd_ready <= ($urandom_range(0, 3) != 0);  // ~25% stall
            if (!icb_rsp_valid || icb_rsp_ready) begin
                if (beat_q.size() > 0 && $urandom_range(0, 2) != 0) begin
                    beat_addr = beat_q.pop_front();
                    icb_rsp_valid <= 1'b1;
                    icb_rsp_rdata <= beat_data(beat_addr);
                end else begin
                    icb_rsp_valid <= 1'b0;  // bubble
                end
            end
        end
    end

endmodule

// File: verif/tb_ia_loader.sv
/*
 * testbench for the activation loader
 * clock, reset, config table, reference model, ICB monitor, watchdog
 */
module tb_ia_loader;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int t_size = ia_pkg::tile_size;
    localparam int n_cfg  = 5;

    // k, n, m, lhs_base, lhs_row_stride_b, lhs_zp
    int cfg_table [n_cfg][6] = '{
        '{ 8,  8,  8, 'h000, 16,      0},   // one full tile
        '{13, 21, 20, 'h100, 32,      5},   // ragged k and n, three m loops
        '{16, 12,  9, 'h400, 12,  32760},   // saturates high
        '{ 5,  3,  8, 'h800,  8, -32760},   // saturates low
        '{24, 16, 16, 'ha00, 20,   -100}
    };

    logic clk, rst_n, init_cfg, send_ia_trigger;
    logic [ia_pkg::reg_width-1:0] k, n, m, lhs_base, lhs_row_stride_b;
    logic signed [ia_pkg::reg_width-1:0] lhs_zp;
    logic icb_cmd_valid, icb_cmd_ready, icb_cmd_read, icb_rsp_valid, icb_rsp_ready;
    logic [ia_pkg::reg_width-1:0] icb_cmd_addr;
    logic [ia_pkg::len_width-1:0] icb_cmd_len;
    logic [ia_pkg::bus_width-1:0] icb_rsp_rdata;
    logic [t_size*ia_pkg::data_width-1:0] ia_out;
    logic ia_row_valid, ia_is_init_data, ia_calc_done, ia_sending_done, ia_data_valid;

    int exp_addr_q [$];  // expected ICB commands, in issue order
    int exp_len_q  [$];

    ia_loader_top dut0 (
        .clk, .rst_n, .init_cfg, .k, .n, .m, .lhs_base, .lhs_row_stride_b, .lhs_zp,
        .send_ia_trigger, .icb_cmd_valid, .icb_cmd_ready, .icb_cmd_read, .icb_cmd_addr,
        .icb_cmd_len, .icb_rsp_valid, .icb_rsp_ready, .icb_rsp_rdata, .ia_out,
        .ia_row_valid, .ia_is_init_data, .ia_calc_done, .ia_sending_done, .ia_data_valid
    );

    icb_mem_model mem0 (
        .clk, .rst_n, .icb_cmd_valid, .icb_cmd_ready, .icb_cmd_read, .icb_cmd_addr,
        .icb_cmd_len, .icb_rsp_valid, .icb_rsp_ready, .icb_rsp_rdata
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic int ceil_tiles(input int x);
        return (x + t_size - 1) / t_size;
    endfunction

    function automatic int tiles_in(input int e);
        return ceil_tiles(cfg_table[e][0]) * ceil_tiles(cfg_table[e][1])
             * ceil_tiles(cfg_table[e][2]);
    endfunction

    // s8 byte plus zero point, clamped to s16
    function automatic logic [15:0] expected_elem(input int addr, input int zpv);
        int v;
        v = $signed(mem0.mem[addr % 4096]);
        v = v + zpv;
        if (v > 32767) v = 32767;
        else if (v < -32768) v = -32768;
        return 16'(v);
    endfunction

    // ==================================================
    // ICB command monitor, sampled mid-cycle
    // ==================================================
    always @(negedge clk) begin
        if (rst_n && icb_cmd_valid && icb_cmd_ready) begin
            if (exp_addr_q.size() == 0) begin
                $display("unexpected ICB command at address %h", icb_cmd_addr);
                $display("*** FAILED ***");
                $fatal(1, "extra ICB command");
            end else begin
                check_value("icb_cmd_addr", 32'(icb_cmd_addr), 32'(exp_addr_q.pop_front()));
                check_value("icb_cmd_len", 32'(icb_cmd_len), 32'(exp_len_q.pop_front()));
                check_value("icb_cmd_read", 32'(icb_cmd_read), 32'd1);
            end
        end
    end

    initial begin : watchdog
        int limit;
        limit = 50;
        for (int e = 0; e < n_cfg; e++) limit += tiles_in(e) * 200;
        repeat (limit) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    // ==================================================
    // main sequence
    // ==================================================
    initial begin : main
        int kk, nn, mm, base, strd, zpv;
        int col_tiles, row_tiles, loops, rows, cols, row_addr;
        void'($urandom(3));
        for (int a = 0; a < 4096; a++) mem0.mem[a] = 8'($urandom);
        rst_n = 1'b0;
        init_cfg = 1'b0;
        send_ia_trigger = 1'b0;
        {k, n, m, lhs_base, lhs_row_stride_b, lhs_zp} = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("icb_cmd_valid", 32'(icb_cmd_valid), 0);  // reset values
        check_value("icb_rsp_ready", 32'(icb_rsp_ready), 0);
        check_value("ia_row_valid", 32'(ia_row_valid), 0);
        check_value("ia_data_valid", 32'(ia_data_valid), 0);
        check_value("ia_sending_done", 32'(ia_sending_done), 0);

        for (int e = 0; e < n_cfg; e++) begin
            kk = cfg_table[e][0];
            nn = cfg_table[e][1];
            mm = cfg_table[e][2];
            base = cfg_table[e][3];
            strd = cfg_table[e][4];
            zpv = cfg_table[e][5];
            row_tiles = ceil_tiles(kk);
            col_tiles = ceil_tiles(nn);
            loops = ceil_tiles(mm);
            // commands for the whole run, tile rows > m loops > col tiles
            for (int tr = 0; tr < row_tiles; tr++)
                for (int lp = 0; lp < loops; lp++)
                    for (int tc = 0; tc < col_tiles; tc++) begin
                        rows = (kk - tr * t_size < t_size) ? kk - tr * t_size : t_size;
                        cols = (nn - tc * t_size < t_size) ? nn - tc * t_size : t_size;
                        for (int r = 0; r < rows; r++) begin
                            exp_addr_q.push_back((base + (tr * t_size + r) * strd
                                                  + tc * t_size) & 'hffff);
                            exp_len_q.push_back((cols + 3) / 4 - 1);
                        end
                    end

            @(posedge clk);
            init_cfg <= 1'b1;
            k <= 16'(kk);
            n <= 16'(nn);
            m <= 16'(mm);
            lhs_base <= 16'(base);
            lhs_row_stride_b <= 16'(strd);
            lhs_zp <= 16'(zpv);
            @(posedge clk);
            init_cfg <= 1'b0;

            for (int tr = 0; tr < row_tiles; tr++)
                for (int lp = 0; lp < loops; lp++)
                    for (int tc = 0; tc < col_tiles; tc++) begin
                        rows = (kk - tr * t_size < t_size) ? kk - tr * t_size : t_size;
                        cols = (nn - tc * t_size < t_size) ? nn - tc * t_size : t_size;
                        while (!ia_data_valid) @(negedge clk);  // tile loaded
                        repeat ($urandom_range(0, 4)) @(posedge clk);
                        @(posedge clk) send_ia_trigger <= 1'b1;
                        @(posedge clk) send_ia_trigger <= 1'b0;
                        for (int r = 0; r < rows; r++) begin
                            @(negedge clk);
                            check_value("ia_row_valid", 32'(ia_row_valid), 1);
                            check_value("ia_sending_done", 32'(ia_sending_done),
                                        32'(r == rows - 1));
                            check_value("ia_is_init_data", 32'(ia_is_init_data),
                                        32'(tc == 0));
                            check_value("ia_calc_done", 32'(ia_calc_done),
                                        32'(tc == col_tiles - 1));
                            if (r == 0)
                                check_value("ia_data_valid", 32'(ia_data_valid), 0);
                            row_addr = base + (tr * t_size + r) * strd + tc * t_size;
                            for (int c = 0; c < cols; c++) begin
                                check_value($sformatf("ia_out row %0d col %0d", r, c),
                                            32'(ia_out[c*16 +: 16]),
                                            32'(expected_elem(row_addr + c, zpv)));
                            end
                        end
                        @(negedge clk);
                        check_value("ia_row_valid", 32'(ia_row_valid), 0);  // no extra row
                    end

            repeat (50) begin  // idle after the final tile
                @(negedge clk);
                check_value("ia_data_valid", 32'(ia_data_valid), 0);
            end
            check_value("pending ICB commands", 32'(exp_addr_q.size()), 0);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: verilog/ia_loader_top.sv
/*
 * activation loader top
 * sequencer, ICB row reader, tile buffer and row sender
 */
module ia_loader_top (
    input  logic                                          clk,
    input  logic                                          rst_n,
    // configuration, sampled in IDLE with init_cfg
    input  logic                                          init_cfg,
    input  logic [ia_pkg::reg_width-1:0]                  k,
    input  logic [ia_pkg::reg_width-1:0]                  n,
    input  logic [ia_pkg::reg_width-1:0]                  m,
    input  logic [ia_pkg::reg_width-1:0]                  lhs_base,
    input  logic [ia_pkg::reg_width-1:0]                  lhs_row_stride_b,
    input  logic signed [ia_pkg::reg_width-1:0]           lhs_zp,
    input  logic                                          send_ia_trigger,
    // ICB read master
    output logic                                          icb_cmd_valid,
    input  logic                                          icb_cmd_ready,
    output logic                                          icb_cmd_read,
    output logic [ia_pkg::reg_width-1:0]                  icb_cmd_addr,
    output logic [ia_pkg::len_width-1:0]                  icb_cmd_len,
    input  logic                                          icb_rsp_valid,
    output logic                                          icb_rsp_ready,
    input  logic [ia_pkg::bus_width-1:0]                  icb_rsp_rdata,
    // to the systolic array
    output logic [ia_pkg::tile_size*ia_pkg::data_width-1:0] ia_out,
    output logic                                          ia_row_valid,
    output logic                                          ia_is_init_data,
    output logic                                          ia_calc_done,
    output logic                                          ia_sending_done,
    output logic                                          ia_data_valid
);

    ia_pkg::loader_state_e                          state;
    logic [ia_pkg::reg_width-1:0]                   tile_addr;
    logic [ia_pkg::reg_width-1:0]                   stride;
    logic signed [ia_pkg::reg_width-1:0]            zp;
    logic [ia_pkg::tile_log2:0]                     tile_rows;   // 1..T
    logic [$clog2(ia_pkg::beats_per_row_max):0]     tile_beats;  // 1..2
    logic                                           first_col_tile;
    logic                                           last_col_tile;
    logic                                           tile_full;
    logic                                           send_done;
    logic [ia_pkg::tile_log2-1:0]                   rd_row;
    logic [ia_pkg::tile_size*ia_pkg::data_width-1:0] rd_data;

    tile_sequencer u_seq (
        .clk, .rst_n, .init_cfg, .k, .n, .m, .lhs_base, .lhs_row_stride_b, .lhs_zp,
        .tile_full, .send_done, .state, .tile_addr, .stride, .zp,
        .tile_rows, .tile_beats, .first_col_tile, .last_col_tile
    );

    icb_row_reader u_rdr (
        .clk, .rst_n, .state, .tile_addr, .stride, .tile_rows, .tile_beats,
        .icb_cmd_ready, .icb_cmd_valid, .icb_cmd_read, .icb_cmd_addr, .icb_cmd_len
    );

    tile_buffer u_buf (
        .clk, .rst_n, .state, .tile_rows, .tile_beats, .zp,
        .icb_rsp_valid, .icb_rsp_rdata, .rd_row,
        .icb_rsp_ready, .tile_full, .rd_data
    );

    row_sender u_snd (
        .clk, .rst_n, .state, .tile_full, .tile_rows, .first_col_tile, .last_col_tile,
        .send_ia_trigger, .rd_data, .rd_row, .ia_out, .ia_row_valid,
        .ia_is_init_data, .ia_calc_done, .ia_sending_done, .ia_data_valid, .send_done
    );

endmodule

// File: verilog/ia_pkg.sv
/*
 * shared definitions for the activation loader
 * tile geometry, bus and field widths, loader states, ICB opcodes
 */
package ia_pkg;

    // ==================================================
    // tile geometry
    // ==================================================
    localparam int tile_size         = 8;   // array width = tile edge
    localparam int tile_log2         = 3;   // all tile math shifts by this
    localparam int data_width        = 16;  // one output element

    // ==================================================
    // bus and field widths
    // ==================================================
    localparam int bus_width         = 32;                          // ICB data
    localparam int bytes_per_beat    = 4;
    localparam int beats_per_row_max = tile_size / bytes_per_beat;  // full tile row
    localparam int reg_width         = 16;  // cfg, address, counters
    localparam int len_width         = 3;   // ICB burst len, beats - 1

    // loader FSM
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        INIT = 2'b11,  // counts derived here
        LOAD = 2'b01,
        SEND = 2'b10
    } loader_state_e;

    // ICB command opcode
    typedef enum logic {
        WRITE = 1'b0,
        READ  = 1'b1
    } icb_op_e;

endpackage

// File: verilog/icb_row_reader.sv
/*
 * ICB row reader
 * one read burst per valid tile row, running row address
 */
module icb_row_reader (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  ia_pkg::loader_state_e                     state,
    input  logic [ia_pkg::reg_width-1:0]              tile_addr,
    input  logic [ia_pkg::reg_width-1:0]              stride,
    input  logic [ia_pkg::tile_log2:0]                tile_rows,
    input  logic [$clog2(ia_pkg::beats_per_row_max):0] tile_beats,
    input  logic                                      icb_cmd_ready,
    output logic                                      icb_cmd_valid,
    output logic                                      icb_cmd_read,
    output logic [ia_pkg::reg_width-1:0]              icb_cmd_addr,
    output logic [ia_pkg::len_width-1:0]              icb_cmd_len
);

    logic [ia_pkg::tile_log2:0] issued;  // rows queued so far

    wire more    = (issued < tile_rows);
    wire advance = !icb_cmd_valid || icb_cmd_ready;  // slot free or taken this cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            icb_cmd_valid <= 1'b0;
            issued        <= '0;
        end else if (state != ia_pkg::LOAD) begin
            icb_cmd_valid <= 1'b0;  // cleared between tiles
            issued        <= '0;
        end else if (advance) begin
            icb_cmd_valid <= more;
            if (more) issued <= issued + 1'b1;
        end
    end

    // address walks by stride, first row at tile base
    always_ff @(posedge clk) begin
        if (state == ia_pkg::LOAD && advance && more)
            icb_cmd_addr <= (issued == '0) ? tile_addr : icb_cmd_addr + stride;
    end

    assign icb_cmd_len  = ia_pkg::len_width'(tile_beats - 1'b1);  // stable through LOAD
    assign icb_cmd_read = ia_pkg::READ;

    a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        icb_cmd_valid && !icb_cmd_ready |=>
            icb_cmd_valid && $stable(icb_cmd_addr) && $stable(icb_cmd_len)
            && $stable(icb_cmd_read));

endmodule

// File: verilog/row_sender.sv
/*
 * row sender
 * one buffered row per cycle to the array, tile flags, done pulse
 */
module row_sender (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  ia_pkg::loader_state_e                     state,
    input  logic                                      tile_full,
    input  logic [ia_pkg::tile_log2:0]                tile_rows,
    input  logic                                      first_col_tile,
    input  logic                                      last_col_tile,
    input  logic                                      send_ia_trigger,
    input  logic [ia_pkg::tile_size*ia_pkg::data_width-1:0] rd_data,
    output logic [ia_pkg::tile_log2-1:0]              rd_row,
    output logic [ia_pkg::tile_size*ia_pkg::data_width-1:0] ia_out,
    output logic                                      ia_row_valid,
    output logic                                      ia_is_init_data,
    output logic                                      ia_calc_done,
    output logic                                      ia_sending_done,
    output logic                                      ia_data_valid,
    output logic                                      send_done
);

    logic busy;  // rows 1.. still to fetch

    wire start = (state == ia_pkg::SEND) && ia_data_valid && send_ia_trigger;
    wire fetch = start || busy;
    wire last  = ({1'b0, rd_row} == tile_rows - 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy            <= 1'b0;
            rd_row          <= '0;
            ia_row_valid    <= 1'b0;
            ia_is_init_data <= 1'b0;
            ia_calc_done    <= 1'b0;
            ia_sending_done <= 1'b0;
            ia_data_valid   <= 1'b0;
        end else begin
            ia_row_valid    <= fetch;
            ia_is_init_data <= fetch && first_col_tile;
            ia_calc_done    <= fetch && last_col_tile;
            ia_sending_done <= fetch && last;  // with the last row
            if (fetch) begin
                busy   <= !last;
                rd_row <= last ? '0 : rd_row + 1'b1;
            end
            if (tile_full)
                ia_data_valid <= 1'b1;  // high from first SEND cycle
            else if (start)
                ia_data_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch) ia_out <= rd_data;
    end

    assign send_done = ia_sending_done;

    a_rows_in_send: assert property (@(posedge clk) disable iff (!rst_n)
        ia_row_valid |-> state == ia_pkg::SEND);

endmodule

// File: verilog/tile_buffer.sv
/*
 * tile buffer
 * ICB response intake, s8 to s16 with zero point, T x T store
 */
module tile_buffer (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  ia_pkg::loader_state_e                     state,
    input  logic [ia_pkg::tile_log2:0]                tile_rows,
    input  logic [$clog2(ia_pkg::beats_per_row_max):0] tile_beats,
    input  logic signed [ia_pkg::reg_width-1:0]       zp,
    input  logic                                      icb_rsp_valid,
    input  logic [ia_pkg::bus_width-1:0]              icb_rsp_rdata,
    input  logic [ia_pkg::tile_log2-1:0]              rd_row,
    output logic                                      icb_rsp_ready,
    output logic                                      tile_full,
    output logic [ia_pkg::tile_size*ia_pkg::data_width-1:0] rd_data
);

    logic [ia_pkg::data_width-1:0] store [ia_pkg::tile_size][ia_pkg::tile_size];
    logic [$clog2(ia_pkg::beats_per_row_max)-1:0] beat_cnt;
    logic [ia_pkg::tile_log2-1:0]                 row_cnt;

    // sign-extend byte, add zp, clamp to s16
    function automatic logic [ia_pkg::data_width-1:0] convert(
        input logic [7:0]                       b,
        input logic [ia_pkg::reg_width-1:0]     zp_in
    );
        logic signed [17:0] sum;
        sum = $signed({{10{b[7]}}, b}) + $signed({{2{zp_in[15]}}, zp_in});
        if (sum > 18'sd32767)
            return 16'h7fff;
        else if (sum < -18'sd32768)
            return 16'h8000;
        else
            return sum[15:0];
    endfunction

    assign icb_rsp_ready = (state == ia_pkg::LOAD);  // never stalls the slave in LOAD

    wire rsp_hs    = icb_rsp_valid && icb_rsp_ready;
    wire last_beat = ({1'b0, beat_cnt} == tile_beats - 1'b1);
    wire last_row  = ({1'b0, row_cnt} == tile_rows - 1'b1);

    assign tile_full = rsp_hs && last_beat && last_row;  // same cycle as final beat

    // ==================================================
    // beat / row counters
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            row_cnt  <= '0;
        end else if (state != ia_pkg::LOAD) begin
            beat_cnt <= '0;
            row_cnt  <= '0;
        end else if (rsp_hs) begin
            beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
            if (last_beat) row_cnt <= row_cnt + 1'b1;
        end
    end

    // four elements per beat, low byte to low column
    always_ff @(posedge clk) begin
        if (rsp_hs) begin
            for (int i = 0; i < ia_pkg::bytes_per_beat; i++) begin
                store[row_cnt][{beat_cnt, i[1:0]}] <= convert(icb_rsp_rdata[8*i +: 8], zp);
            end
        end
    end

    // row read port, same cycle
    for (genvar c = 0; c < ia_pkg::tile_size; c++) begin : g_rd
        assign rd_data[c*ia_pkg::data_width +: ia_pkg::data_width] = store[rd_row][c];
    end

endmodule

// File: verilog/tile_sequencer.sv
/*
 * tile sequencer
 * config latch, tile counts, tile walk, loader FSM
 */
module tile_sequencer (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      init_cfg,
    input  logic [ia_pkg::reg_width-1:0]              k,
    input  logic [ia_pkg::reg_width-1:0]              n,
    input  logic [ia_pkg::reg_width-1:0]              m,
    input  logic [ia_pkg::reg_width-1:0]              lhs_base,
    input  logic [ia_pkg::reg_width-1:0]              lhs_row_stride_b,
    input  logic signed [ia_pkg::reg_width-1:0]       lhs_zp,
    input  logic                                      tile_full,
    input  logic                                      send_done,
    output ia_pkg::loader_state_e                     state,
    output logic [ia_pkg::reg_width-1:0]              tile_addr,
    output logic [ia_pkg::reg_width-1:0]              stride,
    output logic signed [ia_pkg::reg_width-1:0]       zp,
    output logic [ia_pkg::tile_log2:0]                tile_rows,
    output logic [$clog2(ia_pkg::beats_per_row_max):0] tile_beats,
    output logic                                      first_col_tile,
    output logic                                      last_col_tile
);

    logic [ia_pkg::reg_width-1:0] cfg_k, cfg_n, cfg_m, cfg_base;
    logic [ia_pkg::reg_width-1:0] col_tiles;   // ceil(n/T)
    logic [ia_pkg::reg_width-1:0] row_tiles;   // ceil(k/T)
    logic [ia_pkg::reg_width-1:0] loops;       // ceil(m/T)
    logic [ia_pkg::tile_log2:0]   last_rows;   // valid rows, last tile row
    logic [$clog2(ia_pkg::beats_per_row_max):0] last_beats;
    logic [ia_pkg::reg_width-1:0] col_idx, loop_cnt, row_idx;
    logic [ia_pkg::reg_width-1:0] row_base;    // start of current tile row
    logic [ia_pkg::tile_log2:0]   n_rem;       // valid cols of last col tile

    wire last_col  = (col_idx == col_tiles - 1'b1);
    wire last_loop = (loop_cnt == loops - 1'b1);
    wire last_row  = (row_idx == row_tiles - 1'b1);
    wire [ia_pkg::reg_width-1:0] row_step = stride << ia_pkg::tile_log2;

    assign n_rem = (cfg_n[ia_pkg::tile_log2-1:0] == '0) ?
                   (ia_pkg::tile_log2+1)'(ia_pkg::tile_size) :
                   {1'b0, cfg_n[ia_pkg::tile_log2-1:0]};

    // ==================================================
    // config latch and counts
    // ==================================================
    always_ff @(posedge clk) begin
        if (state == ia_pkg::IDLE && init_cfg) begin
            cfg_k    <= k;
            cfg_n    <= n;
            cfg_m    <= m;
            cfg_base <= lhs_base;
            stride   <= lhs_row_stride_b;
            zp       <= lhs_zp;
        end
        if (state == ia_pkg::INIT) begin
            col_tiles  <= (cfg_n + ia_pkg::reg_width'(ia_pkg::tile_size - 1)) >> ia_pkg::tile_log2;
            row_tiles  <= (cfg_k + ia_pkg::reg_width'(ia_pkg::tile_size - 1)) >> ia_pkg::tile_log2;
            loops      <= (cfg_m + ia_pkg::reg_width'(ia_pkg::tile_size - 1)) >> ia_pkg::tile_log2;
            last_rows  <= (cfg_k[ia_pkg::tile_log2-1:0] == '0) ?
                          (ia_pkg::tile_log2+1)'(ia_pkg::tile_size) :
                          {1'b0, cfg_k[ia_pkg::tile_log2-1:0]};
            // round cols up to whole beats
            last_beats <= 2'((n_rem + 4'(ia_pkg::bytes_per_beat - 1))
                          >> $clog2(ia_pkg::bytes_per_beat));
        end
    end

    // ==================================================
    // FSM and tile walk
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ia_pkg::IDLE;
            col_idx   <= '0;
            loop_cnt  <= '0;
            row_idx   <= '0;
            row_base  <= '0;
            tile_addr <= '0;
        end else begin
            case (state)
                ia_pkg::IDLE: if (init_cfg) state <= ia_pkg::INIT;
                ia_pkg::INIT: begin
                    state     <= ia_pkg::LOAD;
                    col_idx   <= '0;
                    loop_cnt  <= '0;
                    row_idx   <= '0;
                    row_base  <= cfg_base;
                    tile_addr <= cfg_base;
                end
                ia_pkg::LOAD: if (tile_full) state <= ia_pkg::SEND;
                ia_pkg::SEND: begin
                    if (send_done) begin
                        state <= (last_col && last_loop && last_row) ? ia_pkg::IDLE
                                                                      : ia_pkg::LOAD;
                        if (!last_col) begin
                            col_idx   <= col_idx + 1'b1;
                            tile_addr <= tile_addr + ia_pkg::reg_width'(ia_pkg::tile_size);
                        end else if (!last_loop) begin  // replay the same tile row
                            col_idx   <= '0;
                            loop_cnt  <= loop_cnt + 1'b1;
                            tile_addr <= row_base;
                        end else begin                  // next tile row
                            col_idx   <= '0;
                            loop_cnt  <= '0;
                            row_idx   <= row_idx + 1'b1;
                            row_base  <= row_base + row_step;
                            tile_addr <= row_base + row_step;
                        end
                    end
                end
                default: state <= ia_pkg::IDLE;
            endcase
        end
    end

    assign tile_rows      = last_row ? last_rows : (ia_pkg::tile_log2+1)'(ia_pkg::tile_size);
    assign tile_beats     = last_col ? last_beats : 2'(ia_pkg::beats_per_row_max);
    assign first_col_tile = (col_idx == '0);
    assign last_col_tile  = last_col;

    // buffer fill only while loading
    a_full_in_load: assert property (@(posedge clk) disable iff (!rst_n)
        tile_full |-> state == ia_pkg::LOAD);

endmodule
